// ==== include/debug_settings.svh ====
`ifndef DEBUG_SETTINGS_SVH
`define DEBUG_SETTINGS_SVH

// debug port widths

// data word, shared by the register file, CC words and PC variants
`define DBG_DATA_W 16

// memory address, also the width of the address register
`define DBG_ADDR_W 16

// register index in the upper nibble of a register read
`define DBG_REG_AW 4

// condition-code word selector
`define DBG_CC_SEL_W 2

// program-counter variant selector
`define DBG_PC_SEL_W 3

`endif

// ==== src/debugPkg.sv ====
`include "debug_settings.svh"

package debugPkg;

	// opcode field, instruction bits 3:1
	// codes 6 and 7 are unused and decode as OP_NONE
	typedef enum logic [2:0] {
		OP_NONE   = 3'd0,
		OP_RD_REG = 3'd1,
		OP_RD_CC  = 3'd2,
		OP_RD_PC  = 3'd3,
		OP_RD_MEM = 3'd4,
		OP_WR_MEM = 3'd5
	} debugOp_e;

	// memory access requested by an instruction
	typedef enum logic [1:0] {
		BUS_NONE,
		BUS_READ,
		BUS_WRITE
	} busSeq_e;

	// source of the data register load multiplexer
	// SEL_DIN is the memory read data
	typedef enum logic [1:0] {
		SEL_DIN,
		SEL_REG,
		SEL_CC,
		SEL_PC
	} dataSel_e;

	// one instruction byte, the upper nibble depends on the opcode
	typedef union packed {
		struct packed {
			logic [`DBG_REG_AW-1:0] regIdx;
			debugOp_e op;
			logic inc;
		} regForm;
		struct packed {
			logic [`DBG_REG_AW-`DBG_CC_SEL_W-1:0] pad;
			logic [`DBG_CC_SEL_W-1:0] ccSel;
			debugOp_e op;
			logic inc;
		} ccForm;
		struct packed {
			logic [`DBG_REG_AW-`DBG_PC_SEL_W-1:0] pad;
			logic [`DBG_PC_SEL_W-1:0] pcSel;
			debugOp_e op;
			logic inc;
		} pcForm;
	} debugInstr_u;

endpackage

// ==== src/debugCtrlIf.sv ====
`include "debug_settings.svh"

interface debugCtrlIf
	import debugPkg::*;
();

	busSeq_e busSeq;
	logic busInc;
	logic regRead;
	logic addrIncNow;
	dataSel_e dataSel;
	logic ldData;
	logic [`DBG_CC_SEL_W-1:0] ccSel;
	logic [`DBG_PC_SEL_W-1:0] pcSel;
	logic [`DBG_REG_AW-1:0] regIdx;

	modport decodeOut (
		output busSeq, busInc, regRead, addrIncNow, dataSel,
		output ldData, ccSel, pcSel, regIdx
	);

	// sequencer and data path only observe the decode
	modport ctrlIn (
		input busSeq, busInc, regRead, addrIncNow, dataSel,
		input ldData, ccSel, pcSel, regIdx
	);

endinterface

// ==== src/debugDecoder.sv ====
`include "debug_settings.svh"

module debugDecoder
	import debugPkg::*;
(
	input logic instrValid,
	input debugInstr_u instr,
	debugCtrlIf.decodeOut ctrl
);

	debugOp_e op;
	logic incFlag;

	// no valid instruction looks exactly like OP_NONE
	assign op = instrValid ? instr.regForm.op : OP_NONE;
	assign incFlag = instr.regForm.inc;

	always_comb begin
		ctrl.busSeq = BUS_NONE;
		ctrl.busInc = 1'b0;
		ctrl.regRead = 1'b0;
		ctrl.addrIncNow = 1'b0;
		ctrl.dataSel = SEL_DIN;
		ctrl.ldData = 1'b0;
		ctrl.ccSel = '0;
		ctrl.pcSel = '0;
		ctrl.regIdx = '0;

		case (op)
			OP_RD_REG: begin
				ctrl.regRead = 1'b1;
				ctrl.regIdx = instr.regForm.regIdx;
				ctrl.addrIncNow = incFlag;
				ctrl.dataSel = SEL_REG;
				ctrl.ldData = 1'b1;
			end

			OP_RD_CC: begin
				ctrl.ccSel = instr.ccForm.ccSel;
				ctrl.dataSel = SEL_CC;
				ctrl.ldData = 1'b1;
			end

			OP_RD_PC: begin
				ctrl.pcSel = instr.pcForm.pcSel;
				ctrl.dataSel = SEL_PC;
				ctrl.ldData = 1'b1;
			end

			// memory data lands later, when the sequencer sees memAck
			OP_RD_MEM: begin
				ctrl.busSeq = BUS_READ;
				ctrl.busInc = incFlag;
				ctrl.dataSel = SEL_DIN;
			end

			OP_WR_MEM: begin
				ctrl.busSeq = BUS_WRITE;
				ctrl.busInc = incFlag;
			end

			default: begin
			end
		endcase
	end

	// an immediate load and a bus access would both write the data register
	always_comb begin
		assert (!(ctrl.ldData && ctrl.busSeq != BUS_NONE))
			else $error("debugDecoder: data load and bus sequence requested together");
	end

endmodule

// ==== src/debugBusSequencer.sv ====
`include "debug_settings.svh"

module debugBusSequencer
	import debugPkg::*;
(
	input logic clk,
	input logic reset,
	debugCtrlIf.ctrlIn ctrl,
	input logic memAck,
	output logic memReq,
	output logic memWrite,
	output logic busy,
	output logic memDone,
	output logic doneRead,
	output logic doneInc
);

	// idle when low, access in progress when high
	logic accessing;
	logic writeLatch;
	logic incLatch;

	always_ff @(posedge clk) begin
		if (reset) begin
			accessing <= 1'b0;
			writeLatch <= 1'b0;
			incLatch <= 1'b0;
		end else if (!accessing) begin
			if (ctrl.busSeq != BUS_NONE) begin
				accessing <= 1'b1;
				writeLatch <= (ctrl.busSeq == BUS_WRITE);
				incLatch <= ctrl.busInc;
			end
		end else if (memAck) begin
			accessing <= 1'b0;
		end
	end

	assign memReq = accessing;
	assign busy = accessing;
	assign memWrite = accessing && writeLatch;

	// the data path acts on the ack edge
	assign memDone = accessing && memAck;
	assign doneRead = memDone && !writeLatch;
	assign doneInc = memDone && incLatch;

	// request is a level and only the memory may end it
	reqHeld: assert property (@(posedge clk) disable iff (reset)
		memReq && !memAck |=> memReq)
		else $error("debugBusSequencer: memReq dropped without memAck");

endmodule

// ==== src/debugDataPath.sv ====
`include "debug_settings.svh"

module debugDataPath
	import debugPkg::*;
(
	input logic clk,
	input logic reset,
	debugCtrlIf.ctrlIn ctrl,
	input logic addrLoad,
	input logic dataLoad,
	input logic [`DBG_DATA_W-1:0] hostData,
	input logic [`DBG_DATA_W-1:0] regData,
	input logic [`DBG_DATA_W-1:0] ccData,
	input logic [`DBG_DATA_W-1:0] pcData,
	input logic [`DBG_DATA_W-1:0] memRdata,
	input logic memDone,
	input logic doneRead,
	input logic doneInc,
	input logic busy,
	output logic [`DBG_ADDR_W-1:0] addr,
	output logic [`DBG_DATA_W-1:0] dataOut
);

	localparam logic [`DBG_ADDR_W-1:0] addrStep = 1;

	logic [`DBG_DATA_W-1:0] selData;
	logic addrInc;

	// load multiplexer for immediate reads
	always_comb begin
		case (ctrl.dataSel)
			SEL_REG: selData = regData;
			SEL_CC: selData = ccData;
			SEL_PC: selData = pcData;
			default: selData = memRdata;
		endcase
	end

	// register reads step now, memory ops step on the ack
	assign addrInc = ctrl.addrIncNow || (memDone && doneInc);

	always_ff @(posedge clk) begin
		if (reset) begin
			addr <= '0;
		end else if (addrLoad) begin
			addr <= hostData[`DBG_ADDR_W-1:0];
		end else if (addrInc) begin
			addr <= addr + addrStep;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dataOut <= '0;
		end else if (dataLoad) begin
			dataOut <= hostData;
		end else if (ctrl.ldData) begin
			dataOut <= selData;
		end else if (memDone && doneRead) begin
			dataOut <= memRdata;
		end
	end

	// host must wait for busy to fall before anything new
	noStrobeWhileBusy: assert property (@(posedge clk) disable iff (reset)
		busy |-> !(addrLoad || dataLoad || ctrl.ldData || ctrl.addrIncNow ||
			ctrl.busSeq != BUS_NONE))
		else $error("debugDataPath: host strobe while busy");

	// memAddr comes straight from addr and has to hold for the whole request
	addrHeld: assert property (@(posedge clk) disable iff (reset)
		busy && !memDone |=> $stable(addr))
		else $error("debugDataPath: addr moved during a memory access");

endmodule

// ==== src/debugPort.sv ====
`include "debug_settings.svh"

module debugPort (
	input logic clk,
	input logic reset,

	// host side
	input logic instrValid,
	input logic [7:0] instr,
	input logic addrLoad,
	input logic dataLoad,
	input logic [`DBG_DATA_W-1:0] hostData,
	output logic [`DBG_DATA_W-1:0] dataOut,
	output logic [`DBG_ADDR_W-1:0] addr,
	output logic busy,

	// cpu side, all answered combinationally
	output logic [`DBG_REG_AW-1:0] regAddr,
	output logic regRead,
	input logic [`DBG_DATA_W-1:0] regData,
	output logic [`DBG_CC_SEL_W-1:0] ccSel,
	input logic [`DBG_DATA_W-1:0] ccData,
	output logic [`DBG_PC_SEL_W-1:0] pcSel,
	input logic [`DBG_DATA_W-1:0] pcData,

	// memory bus
	output logic memReq,
	output logic memWrite,
	output logic [`DBG_ADDR_W-1:0] memAddr,
	output logic [`DBG_DATA_W-1:0] memWdata,
	input logic [`DBG_DATA_W-1:0] memRdata,
	input logic memAck
);

	logic memDone;
	logic doneRead;
	logic doneInc;

	debugCtrlIf ctrlBus ();

	debugDecoder decoder (
		.instrValid (instrValid),
		.instr      (instr),
		.ctrl       (ctrlBus.decodeOut)
	);

	debugBusSequencer sequencer (
		.clk      (clk),
		.reset    (reset),
		.ctrl     (ctrlBus.ctrlIn),
		.memAck   (memAck),
		.memReq   (memReq),
		.memWrite (memWrite),
		.busy     (busy),
		.memDone  (memDone),
		.doneRead (doneRead),
		.doneInc  (doneInc)
	);

	debugDataPath dataPath (
		.clk      (clk),
		.reset    (reset),
		.ctrl     (ctrlBus.ctrlIn),
		.addrLoad (addrLoad),
		.dataLoad (dataLoad),
		.hostData (hostData),
		.regData  (regData),
		.ccData   (ccData),
		.pcData   (pcData),
		.memRdata (memRdata),
		.memDone  (memDone),
		.doneRead (doneRead),
		.doneInc  (doneInc),
		.busy     (busy),
		.addr     (addr),
		.dataOut  (dataOut)
	);

	// selectors go out unregistered, the cpu answers in the same cycle
	assign regAddr = ctrlBus.regIdx;
	assign regRead = ctrlBus.regRead;
	assign ccSel = ctrlBus.ccSel;
	assign pcSel = ctrlBus.pcSel;

	// the bus uses the debug registers directly
	assign memAddr = addr;
	assign memWdata = dataOut;

endmodule

// ==== dv/debugPortTb.sv ====
`include "debug_settings.svh"

module debugPortTb
	import debugPkg::*;
();

	typedef logic [`DBG_REG_AW-1:0] selWord_t;

	// about 300 operations at up to 10 cycles each plus margin
	localparam int timeoutCycles = 5000;

	logic clk;
	logic reset;
	logic instrValid;
	logic [7:0] instr;
	logic addrLoad;
	logic dataLoad;
	logic [`DBG_DATA_W-1:0] hostData;
	logic [`DBG_DATA_W-1:0] dataOut;
	logic [`DBG_ADDR_W-1:0] addr;
	logic busy;
	logic [`DBG_REG_AW-1:0] regAddr;
	logic regRead;
	logic [`DBG_DATA_W-1:0] regData;
	logic [`DBG_CC_SEL_W-1:0] ccSel;
	logic [`DBG_DATA_W-1:0] ccData;
	logic [`DBG_PC_SEL_W-1:0] pcSel;
	logic [`DBG_DATA_W-1:0] pcData;
	logic memReq;
	logic memWrite;
	logic [`DBG_ADDR_W-1:0] memAddr;
	logic [`DBG_DATA_W-1:0] memWdata;
	logic [`DBG_DATA_W-1:0] memRdata;
	logic memAck;

	// cpu and memory models
	logic [`DBG_DATA_W-1:0] regFile [16];
	logic [`DBG_DATA_W-1:0] ccWords [4];
	logic [`DBG_DATA_W-1:0] pcWords [8];
	logic [`DBG_DATA_W-1:0] memModel [1 << `DBG_ADDR_W];

	int seed = 32'h939c_a581;
	int errorCount;
	int checkCount;
	int cycleCount;
	logic [`DBG_ADDR_W-1:0] expAddr;

	debugPort dut (
		.clk        (clk),
		.reset      (reset),
		.instrValid (instrValid),
		.instr      (instr),
		.addrLoad   (addrLoad),
		.dataLoad   (dataLoad),
		.hostData   (hostData),
		.dataOut    (dataOut),
		.addr       (addr),
		.busy       (busy),
		.regAddr    (regAddr),
		.regRead    (regRead),
		.regData    (regData),
		.ccSel      (ccSel),
		.ccData     (ccData),
		.pcSel      (pcSel),
		.pcData     (pcData),
		.memReq     (memReq),
		.memWrite   (memWrite),
		.memAddr    (memAddr),
		.memWdata   (memWdata),
		.memRdata   (memRdata),
		.memAck     (memAck)
	);

	assign regData = regFile[regAddr];
	assign ccData = ccWords[ccSel];
	assign pcData = pcWords[pcSel];

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [`DBG_DATA_W-1:0] randData();
		logic [31:0] r;
		r = $random(seed);
		return r[`DBG_DATA_W-1:0];
	endfunction

	function automatic logic randBit();
		logic [31:0] r;
		r = $random(seed);
		return r[7];
	endfunction

	// memory answers each request after 0 to 5 idle cycles
	initial begin : memResponder
		logic [31:0] r;
		int delay;
		memAck = 1'b0;
		memRdata = '0;
		for (int i = 0; i < (1 << `DBG_ADDR_W); i++) begin
			memModel[i] = {i[7:0], i[15:8]} ^ 16'h5ac3;
		end
		forever begin
			@(posedge clk);
			#1;
			if (memReq) begin
				r = $random(seed);
				delay = r % 6;
				repeat (delay) begin
					@(posedge clk);
					#1;
				end
				if (memWrite) begin
					memModel[memAddr] = memWdata;
				end else begin
					memRdata = memModel[memAddr];
				end
				memAck = 1'b1;
				@(posedge clk);
				#1;
				memAck = 1'b0;
			end
		end
	end

	initial begin : watchdog
		cycleCount = 0;
		while (cycleCount < timeoutCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	task automatic checkData(input string name, input logic [`DBG_DATA_W-1:0] expected,
		input logic [`DBG_DATA_W-1:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkAddr(input string name, input logic [`DBG_ADDR_W-1:0] expected,
		input logic [`DBG_ADDR_W-1:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkSel(input string name, input selWord_t expected, input selWord_t actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Error: %s expected %b actual %b", name, expected, actual);
		end
	endtask

	task automatic loadAddr(input logic [`DBG_ADDR_W-1:0] value);
		addrLoad = 1'b1;
		hostData = value;
		@(posedge clk);
		#1;
		addrLoad = 1'b0;
		expAddr = value;
	endtask

	task automatic loadData(input logic [`DBG_DATA_W-1:0] value);
		dataLoad = 1'b1;
		hostData = value;
		@(posedge clk);
		#1;
		dataLoad = 1'b0;
	endtask

	task automatic waitIdle();
		while (busy) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic resetState();
		checkFlag("reset busy", 1'b0, busy);
		checkFlag("reset memReq", 1'b0, memReq);
		checkAddr("reset addr", '0, addr);
		checkData("reset dataOut", '0, dataOut);
	endtask

	task automatic hostLoads();
		logic [`DBG_DATA_W-1:0] value;
		value = randData();
		loadAddr(value);
		checkAddr("host addrLoad", value, addr);
		value = randData();
		loadData(value);
		checkData("host dataLoad", value, dataOut);
		// both strobes in one cycle take the same word
		value = randData();
		addrLoad = 1'b1;
		dataLoad = 1'b1;
		hostData = value;
		@(posedge clk);
		#1;
		addrLoad = 1'b0;
		dataLoad = 1'b0;
		expAddr = value;
		checkAddr("host both addr", value, addr);
		checkData("host both data", value, dataOut);
	endtask

	task automatic registerReads();
		string name;
		for (int idx = 0; idx < 16; idx++) begin
			for (int inc = 0; inc < 2; inc++) begin
				name = $sformatf("reg read %0d inc %0d", idx, inc);
				instrValid = 1'b1;
				instr = {idx[3:0], OP_RD_REG, inc[0]};
				#1;
				checkSel(name, idx[3:0], regAddr);
				checkFlag(name, 1'b1, regRead);
				@(posedge clk);
				#1;
				instrValid = 1'b0;
				instr = '0;
				if (inc[0]) begin
					expAddr = expAddr + 16'd1;
				end
				checkData(name, regFile[idx], dataOut);
				checkAddr(name, expAddr, addr);
				checkFlag(name, 1'b0, busy);
			end
		end
	endtask

	task automatic selectorReads();
		string name;
		for (int sel = 0; sel < 4; sel++) begin
			name = $sformatf("cc read %0d", sel);
			instrValid = 1'b1;
			instr = {2'b00, sel[1:0], OP_RD_CC, 1'b0};
			#1;
			checkSel(name, selWord_t'(sel[1:0]), selWord_t'(ccSel));
			@(posedge clk);
			#1;
			instrValid = 1'b0;
			checkData(name, ccWords[sel], dataOut);
		end
		for (int sel = 0; sel < 8; sel++) begin
			name = $sformatf("pc read %0d", sel);
			instrValid = 1'b1;
			instr = {1'b0, sel[2:0], OP_RD_PC, 1'b0};
			#1;
			checkSel(name, selWord_t'(sel[2:0]), selWord_t'(pcSel));
			@(posedge clk);
			#1;
			instrValid = 1'b0;
			checkData(name, pcWords[sel], dataOut);
		end
		instr = '0;
		checkAddr("selector reads addr", expAddr, addr);
	endtask

	// busy rises at the instruction edge and addr steps when it falls
	task automatic memOp(input string name, input debugOp_e op, input logic inc);
		instrValid = 1'b1;
		instr = {4'h0, op, inc};
		@(posedge clk);
		#1;
		instrValid = 1'b0;
		instr = '0;
		checkFlag({name, " busy"}, 1'b1, busy);
		checkFlag({name, " memReq"}, 1'b1, memReq);
		checkFlag({name, " memWrite"}, op == OP_WR_MEM, memWrite);
		checkAddr({name, " memAddr"}, expAddr, memAddr);
		waitIdle();
		if (inc) begin
			expAddr = expAddr + 16'd1;
		end
		checkFlag({name, " memReq low"}, 1'b0, memReq);
		checkAddr(name, expAddr, addr);
	endtask

	task automatic memoryAccess();
		logic [`DBG_ADDR_W-1:0] addrList [$];
		logic [`DBG_DATA_W-1:0] burstData [4];
		logic [`DBG_ADDR_W-1:0] base;
		logic [`DBG_DATA_W-1:0] wData;
		string name;
		for (int n = 0; n < 24; n++) begin
			name = $sformatf("mem write %0d", n);
			base = randData();
			wData = randData();
			loadAddr(base);
			loadData(wData);
			memOp(name, OP_WR_MEM, randBit());
			checkData(name, wData, memModel[base]);
			checkData({name, " dataOut"}, wData, dataOut);
			addrList.push_back(base);
		end
		foreach (addrList[n]) begin
			name = $sformatf("mem read %0d", n);
			loadAddr(addrList[n]);
			memOp(name, OP_RD_MEM, randBit());
			checkData(name, memModel[addrList[n]], dataOut);
		end
		// burst through consecutive addresses using the increment flag
		base = randData();
		loadAddr(base);
		for (int k = 0; k < 4; k++) begin
			burstData[k] = randData();
			loadData(burstData[k]);
			memOp($sformatf("burst write %0d", k), OP_WR_MEM, 1'b1);
		end
		loadAddr(base);
		for (int k = 0; k < 4; k++) begin
			name = $sformatf("burst read %0d", k);
			memOp(name, OP_RD_MEM, 1'b1);
			checkData(name, burstData[k], dataOut);
		end
	endtask

	task automatic unusedOps();
		logic [`DBG_DATA_W-1:0] oldData;
		logic [2:0] codes [3];
		string name;
		codes[0] = OP_NONE;
		codes[1] = 3'd6;
		codes[2] = 3'd7;
		oldData = randData();
		loadData(oldData);
		foreach (codes[n]) begin
			name = $sformatf("unused op %0d", codes[n]);
			instrValid = 1'b1;
			instr = {4'hf, codes[n], 1'b1};
			@(posedge clk);
			#1;
			instrValid = 1'b0;
			instr = '0;
			checkAddr(name, expAddr, addr);
			checkData(name, oldData, dataOut);
			checkFlag({name, " busy"}, 1'b0, busy);
			checkFlag({name, " memReq"}, 1'b0, memReq);
		end
	endtask

	initial begin : main
		errorCount = 0;
		checkCount = 0;
		expAddr = '0;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		addrLoad = 1'b0;
		dataLoad = 1'b0;
		hostData = '0;
		for (int i = 0; i < 16; i++) begin
			regFile[i] = randData();
		end
		for (int i = 0; i < 4; i++) begin
			ccWords[i] = randData();
		end
		for (int i = 0; i < 8; i++) begin
			pcWords[i] = randData();
		end
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		resetState();
		hostLoads();
		registerReads();
		selectorReads();
		memoryAccess();
		unusedOps();

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+include
src/debugPkg.sv
src/debugCtrlIf.sv
src/debugDecoder.sv
src/debugBusSequencer.sv
src/debugDataPath.sv
src/debugPort.sv
dv/debugPortTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module debugPortTb -Mdir obj_dir -o simv -f all.f \
	|| { echo "build failed"; exit 1; }
./obj_dir/simv | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }
